/* verilog.f */
verilog/buffet_pkg.sv
verilog/buffet_window.sv
verilog/buffet_update_tracker.sv
verilog/buffet_read_ctrl.sv
verilog/buffet_data_ram.sv
verilog/buffet_top.sv
tests/buffet_tb.sv

/* Bender.yml */
package:
  name: buffet

sources:
  - verilog/buffet_pkg.sv
  - verilog/buffet_window.sv
  - verilog/buffet_update_tracker.sv
  - verilog/buffet_read_ctrl.sv
  - verilog/buffet_data_ram.sv
  - verilog/buffet_top.sv
  - target: test
    files:
      - tests/buffet_tb.sv

/* tests/buffet_tb.sv */
/*
 * Buffet testbench
 * Applies a table of push, credit, read, update and consumer-ready steps
 * to the buffet top level and checks credit replies and read data
 * against a model of every push and update
 */
`timescale 1ns/1ps

module buffet_tb;

    typedef enum logic [2:0] {
        OP_PUSH,
        OP_CREDIT,
        OP_READ,
        OP_UPDATE,
        OP_SET_RDY,
        OP_IDLE
    } op_e;

    // Value is expected credit, read or update offset, shrink amount or ready level
    typedef struct packed {
        op_e op;
        buffet_pkg::count_t value;
        logic will_update;
        logic is_shrink;
        buffet_pkg::data_t data;
    } step_t;

    logic clk;
    logic nreset_i;
    logic push_valid_i;
    buffet_pkg::data_t push_data_i;
    logic credit_req_i;
    logic credit_valid_o;
    buffet_pkg::count_t credit_o;
    logic read_valid_i;
    buffet_pkg::read_req_t read_req_i;
    logic read_ready_o;
    logic read_data_valid_o;
    buffet_pkg::data_t read_data_o;
    logic read_data_ready_i;
    logic update_valid_i;
    buffet_pkg::idx_t update_offset_i;
    buffet_pkg::data_t update_data_i;

    step_t steps[$];
    // Model of the buffer indexed by unwrapped position
    buffet_pkg::data_t model_mem [32];
    int head_pos;
    int tail_pos;
    int read_pos_q[$];
    buffet_pkg::count_t credit_exp_q[$];
    integer seed;
    int cycle_count;
    int cycle_limit;
    logic credit_req_d;
    logic rdy_d;

    buffet_top dut (
        .clk               (clk),
        .nreset_i          (nreset_i),
        .push_valid_i      (push_valid_i),
        .push_data_i       (push_data_i),
        .credit_req_i      (credit_req_i),
        .credit_valid_o    (credit_valid_o),
        .credit_o          (credit_o),
        .read_valid_i      (read_valid_i),
        .read_req_i        (read_req_i),
        .read_ready_o      (read_ready_o),
        .read_data_valid_o (read_data_valid_o),
        .read_data_o       (read_data_o),
        .read_data_ready_i (read_data_ready_i),
        .update_valid_i    (update_valid_i),
        .update_offset_i   (update_offset_i),
        .update_data_i     (update_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------------------

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input buffet_pkg::data_t got,
                              input buffet_pkg::data_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s got 0x%h expected 0x%h",
                                      name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input buffet_pkg::count_t got,
                               input buffet_pkg::count_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s got 0x%h expected 0x%h",
                                      name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s got 0x%h expected 0x%h",
                                      name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------

    task automatic add_step(input op_e op, input int value, input logic wu,
                            input logic shrink, input buffet_pkg::data_t data);
        step_t s;
        s.op = op;
        s.value = buffet_pkg::count_t'(value);
        s.will_update = wu;
        s.is_shrink = shrink;
        s.data = data;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // Empty buffer after reset
        add_step(OP_CREDIT, 16, 0, 0, '0);
        repeat (10) add_step(OP_PUSH, 0, 0, 0, '0);
        add_step(OP_CREDIT, 6, 0, 0, '0);
        // Plain reads at a few offsets
        add_step(OP_READ, 0, 0, 0, '0);
        add_step(OP_READ, 3, 0, 0, '0);
        add_step(OP_READ, 9, 0, 0, '0);
        // WAR hazard as offset 10 is not filled until the next push
        add_step(OP_READ, 10, 0, 0, '0);
        repeat (6) add_step(OP_PUSH, 0, 0, 0, '0);
        add_step(OP_CREDIT, 0, 0, 0, '0);
        // RAW hazard where the second read waits for the write-back
        add_step(OP_READ, 2, 1, 0, '0);
        add_step(OP_READ, 2, 0, 0, '0);
        add_step(OP_UPDATE, 2, 0, 0, 32'h5a5a_c0de);
        // Shrink by 4
        add_step(OP_READ, 4, 0, 1, '0);
        add_step(OP_CREDIT, 4, 0, 0, '0);
        add_step(OP_READ, 0, 0, 0, '0);
        // Read at offset 0 issues before the consumer stalls
        add_step(OP_IDLE, 0, 0, 0, '0);
        // Consumer back-pressure
        add_step(OP_SET_RDY, 0, 0, 0, '0);
        add_step(OP_READ, 5, 0, 0, '0);
        repeat (4) add_step(OP_IDLE, 0, 0, 0, '0);
        add_step(OP_SET_RDY, 1, 0, 0, '0);
        repeat (2) add_step(OP_IDLE, 0, 0, 0, '0);
        // Tail wraps past the end of the RAM
        repeat (2) add_step(OP_PUSH, 0, 0, 0, '0);
        add_step(OP_READ, 13, 0, 0, '0);
        add_step(OP_CREDIT, 2, 0, 0, '0);
        repeat (3) add_step(OP_IDLE, 0, 0, 0, '0);
    endtask

    // Called 1 ns after a rising edge
    task automatic apply_step(input step_t s);
        push_valid_i = 1'b0;
        credit_req_i = 1'b0;
        read_valid_i = 1'b0;
        update_valid_i = 1'b0;
        case (s.op)
            OP_PUSH: begin
                push_data_i = $random(seed);
                push_valid_i = 1'b1;
                model_mem[tail_pos] = push_data_i;
                tail_pos++;
            end
            OP_CREDIT: begin
                credit_req_i = 1'b1;
                credit_exp_q.push_back(s.value);
            end
            OP_READ: begin
                // Ready depends only on registers, so it holds to the next edge
                while (!read_ready_o) begin
                    @(posedge clk);
                    #1;
                end
                read_valid_i = 1'b1;
                read_req_i.offset = buffet_pkg::idx_t'(s.value);
                read_req_i.will_update = s.will_update;
                read_req_i.is_shrink = s.is_shrink;
                if (s.is_shrink) begin
                    head_pos += s.value;
                end else begin
                    read_pos_q.push_back(head_pos + s.value);
                end
            end
            OP_UPDATE: begin
                update_valid_i = 1'b1;
                update_offset_i = buffet_pkg::idx_t'(s.value);
                update_data_i = s.data;
                model_mem[head_pos + s.value] = s.data;
            end
            OP_SET_RDY: read_data_ready_i = s.value[0];
            default: ;
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Monitors sampled on the falling edge
    // ------------------------------------------------------------------------

    // Credit reply exactly one cycle after its request
    always @(negedge clk) begin
        if (nreset_i) begin
            check_flag("credit_valid_o", credit_valid_o, credit_req_d);
            if (credit_valid_o) begin
                check_count("credit_o", credit_o, credit_exp_q.pop_front());
            end
        end
        credit_req_d = credit_req_i;
    end

    always @(negedge clk) begin : data_monitor
        int pos;
        if (nreset_i && read_data_valid_o) begin
            if (!rdy_d) begin
                stop_with_error("read data returned while the consumer was not ready");
            end else if (read_pos_q.size() == 0) begin
                stop_with_error("read data returned with no read outstanding");
            end else begin
                pos = read_pos_q.pop_front();
                check_data("read_data_o", read_data_o, model_mem[pos]);
            end
        end
        rdy_d = read_data_ready_i;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            stop_with_error($sformatf("timeout, test did not finish in %0d cycles",
                                      cycle_limit));
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        nreset_i = 1'b0;
        push_valid_i = 1'b0;
        push_data_i = '0;
        credit_req_i = 1'b0;
        read_valid_i = 1'b0;
        read_req_i = '0;
        read_data_ready_i = 1'b1;
        update_valid_i = 1'b0;
        update_offset_i = '0;
        update_data_i = '0;
        credit_req_d = 1'b0;
        rdy_d = 1'b1;
        head_pos = 0;
        tail_pos = 0;
        cycle_count = 0;
        seed = 32'hf8003b1d;
        build_table();
        cycle_limit = 20 * steps.size();

        repeat (8) @(posedge clk);
        #1;
        nreset_i = 1'b1;
        // Nothing to read or reply to out of reset
        check_flag("read_ready_o", read_ready_o, 1'b0);
        check_flag("credit_valid_o", credit_valid_o, 1'b0);
        check_flag("read_data_valid_o", read_data_valid_o, 1'b0);

        foreach (steps[i]) begin
            @(posedge clk);
            #1;
            apply_step(steps[i]);
        end
        @(posedge clk);
        #1;
        push_valid_i = 1'b0;
        credit_req_i = 1'b0;
        read_valid_i = 1'b0;
        update_valid_i = 1'b0;
        @(negedge clk);

        if (read_pos_q.size() != 0 || credit_exp_q.size() != 0) begin
            stop_with_error("read data or credit replies still expected at end of test");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* verilog/buffet_top.sv */
/*
 * Buffet top level
 * Circular buffer filled in order by a producer and read by offset from
 * the head, with credit replies, shrink and tracked write-backs
 */
`timescale 1ns/1ps

module buffet_top (
    input  logic                  clk,
    input  logic                  nreset_i,
    // Push
    input  logic                  push_valid_i,
    input  buffet_pkg::data_t     push_data_i,
    // Credit
    input  logic                  credit_req_i,
    output logic                  credit_valid_o,
    output buffet_pkg::count_t    credit_o,
    // Read request and data
    input  logic                  read_valid_i,
    input  buffet_pkg::read_req_t read_req_i,
    output logic                  read_ready_o,
    output logic                  read_data_valid_o,
    output buffet_pkg::data_t     read_data_o,
    input  logic                  read_data_ready_i,
    // Update
    input  logic                  update_valid_i,
    input  buffet_pkg::idx_t      update_offset_i,
    input  buffet_pkg::data_t     update_data_i
);

    buffet_pkg::idx_t head;
    buffet_pkg::count_t occupancy;
    logic shrink;
    buffet_pkg::idx_t shrink_amount;
    logic match;
    logic sb_full;
    logic alloc;
    buffet_pkg::idx_t probe_idx;
    logic ram_rd_en;
    buffet_pkg::idx_t ram_rd_idx;
    buffet_pkg::wr_port_t push_wr;
    buffet_pkg::wr_port_t update_wr;

    buffet_window u_window (
        .clk             (clk),
        .nreset_i        (nreset_i),
        .push_valid_i    (push_valid_i),
        .push_data_i     (push_data_i),
        .credit_req_i    (credit_req_i),
        .shrink_i        (shrink),
        .shrink_amount_i (shrink_amount),
        .head_o          (head),
        .occupancy_o     (occupancy),
        .credit_valid_o  (credit_valid_o),
        .credit_o        (credit_o),
        .push_wr_o       (push_wr)
    );

    buffet_update_tracker u_tracker (
        .clk             (clk),
        .nreset_i        (nreset_i),
        .update_valid_i  (update_valid_i),
        .update_offset_i (update_offset_i),
        .update_data_i   (update_data_i),
        .head_i          (head),
        .alloc_i         (alloc),
        .alloc_idx_i     (probe_idx),
        .probe_idx_i     (probe_idx),
        .match_o         (match),
        .full_o          (sb_full),
        .update_wr_o     (update_wr)
    );

    buffet_read_ctrl u_read_ctrl (
        .clk               (clk),
        .nreset_i          (nreset_i),
        .read_valid_i      (read_valid_i),
        .read_req_i        (read_req_i),
        .read_data_ready_i (read_data_ready_i),
        .head_i            (head),
        .occupancy_i       (occupancy),
        .match_i           (match),
        .full_i            (sb_full),
        .read_ready_o      (read_ready_o),
        .shrink_o          (shrink),
        .shrink_amount_o   (shrink_amount),
        .alloc_o           (alloc),
        .probe_idx_o       (probe_idx),
        .ram_rd_en_o       (ram_rd_en),
        .ram_rd_idx_o      (ram_rd_idx),
        .read_data_valid_o (read_data_valid_o)
    );

    buffet_data_ram u_ram (
        .clk         (clk),
        .push_wr_i   (push_wr),
        .update_wr_i (update_wr),
        .rd_en_i     (ram_rd_en),
        .rd_idx_i    (ram_rd_idx),
        .rd_data_o   (read_data_o)
    );

endmodule

/* verilog/buffet_data_ram.sv */
/*
 * Buffet data RAM
 * DEPTH entries of DATA_W bits with a push write port, an update
 * write port and one registered read port
 */
`timescale 1ns/1ps

module buffet_data_ram (
    input  logic                 clk,
    input  buffet_pkg::wr_port_t push_wr_i,
    input  buffet_pkg::wr_port_t update_wr_i,
    input  logic                 rd_en_i,
    input  buffet_pkg::idx_t     rd_idx_i,
    output buffet_pkg::data_t    rd_data_o
);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    buffet_pkg::data_t mem [buffet_pkg::DEPTH];

    // Push writes at the tail and update writes inside the window
    // The two never target the same entry
    always_ff @(posedge clk) begin
        if (push_wr_i.en) begin
            mem[push_wr_i.idx] <= push_wr_i.data;
        end
        if (update_wr_i.en) begin
            mem[update_wr_i.idx] <= update_wr_i.data;
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_idx_i];
        end
    end

endmodule

/* verilog/buffet_read_ctrl.sv */
/*
 * Buffet read control
 * Accepts read and shrink requests, holds one read until its WAR, RAW,
 * consumer-ready and scoreboard-full conditions clear, then issues the
 * RAM read and scoreboard allocation and pulses data valid a cycle later
 */
`timescale 1ns/1ps

module buffet_read_ctrl (
    input  logic                  clk,
    input  logic                  nreset_i,
    input  logic                  read_valid_i,
    input  buffet_pkg::read_req_t read_req_i,
    input  logic                  read_data_ready_i,
    input  buffet_pkg::idx_t      head_i,
    input  buffet_pkg::count_t    occupancy_i,
    input  logic                  match_i,
    input  logic                  full_i,
    output logic                  read_ready_o,
    output logic                  shrink_o,
    output buffet_pkg::idx_t      shrink_amount_o,
    output logic                  alloc_o,
    output buffet_pkg::idx_t      probe_idx_o,
    output logic                  ram_rd_en_o,
    output buffet_pkg::idx_t      ram_rd_idx_o,
    output logic                  read_data_valid_o
);

    buffet_pkg::rd_state_e state_q;

    // Held read
    buffet_pkg::idx_t offset_q;
    buffet_pkg::idx_t abs_idx_q;
    logic will_update_q;

    logic accept;
    logic war_clear;
    logic sb_room;
    logic issue;

    // ------------------------------------------------------------------------
    // Acceptance
    // ------------------------------------------------------------------------

    // Only one read in flight, and nothing to read while empty
    assign read_ready_o = (state_q == buffet_pkg::RD_IDLE) && (occupancy_i != '0);
    assign accept = read_valid_i && read_ready_o;

    // Shrink acts at the accept edge and never waits
    assign shrink_o = accept && read_req_i.is_shrink;
    assign shrink_amount_o = read_req_i.offset;

    // ------------------------------------------------------------------------
    // Hazard wait
    // ------------------------------------------------------------------------

    // WAR: the offset has to be filled already
    assign war_clear = buffet_pkg::count_t'(offset_q) < occupancy_i;
    // A will-update read needs a scoreboard slot
    assign sb_room = !will_update_q || !full_i;
    // match_i covers RAW against the held index
    assign issue = (state_q == buffet_pkg::RD_WAIT) && war_clear && !match_i &&
                   read_data_ready_i && sb_room;

    always_ff @(posedge clk or negedge nreset_i) begin
        if (!nreset_i) begin
            state_q <= buffet_pkg::RD_IDLE;
        end else begin
            case (state_q)
                buffet_pkg::RD_IDLE: begin
                    if (accept && !read_req_i.is_shrink) begin
                        state_q <= buffet_pkg::RD_WAIT;
                    end
                end
                buffet_pkg::RD_WAIT: begin
                    if (issue) begin
                        state_q <= buffet_pkg::RD_IDLE;
                    end
                end
                default: state_q <= buffet_pkg::RD_IDLE;
            endcase
        end
    end

    // Absolute index fixed at accept, head cannot move while held
    always_ff @(posedge clk) begin
        if (accept && !read_req_i.is_shrink) begin
            offset_q <= read_req_i.offset;
            abs_idx_q <= head_i + read_req_i.offset;
            will_update_q <= read_req_i.will_update;
        end
    end

    // ------------------------------------------------------------------------
    // Issue
    // ------------------------------------------------------------------------

    assign probe_idx_o = abs_idx_q;
    assign alloc_o = issue && will_update_q;
    assign ram_rd_en_o = issue;
    assign ram_rd_idx_o = abs_idx_q;

    // RAM read port is registered, so valid trails issue by one cycle
    always_ff @(posedge clk or negedge nreset_i) begin
        if (!nreset_i) begin
            read_data_valid_o <= 1'b0;
        end else begin
            read_data_valid_o <= issue;
        end
    end

endmodule

/* verilog/buffet_update_tracker.sv */
/*
 * Buffet update tracker
 * Scoreboard of entries read with will-update and not yet written back.
 * Registers write-backs, clears their scoreboard entry and drives the
 * update write port of the RAM one cycle after arrival
 */
`timescale 1ns/1ps

module buffet_update_tracker (
    input  logic                 clk,
    input  logic                 nreset_i,
    input  logic                 update_valid_i,
    input  buffet_pkg::idx_t     update_offset_i,
    input  buffet_pkg::data_t    update_data_i,
    input  buffet_pkg::idx_t     head_i,
    input  logic                 alloc_i,
    input  buffet_pkg::idx_t     alloc_idx_i,
    input  buffet_pkg::idx_t     probe_idx_i,
    output logic                 match_o,
    output logic                 full_o,
    output buffet_pkg::wr_port_t update_wr_o
);

    // Scoreboard entries
    logic [buffet_pkg::SB_DEPTH-1:0] sb_valid_q;
    buffet_pkg::idx_t sb_idx_q [buffet_pkg::SB_DEPTH];

    // Registered write-back
    logic upd_valid_q;
    buffet_pkg::idx_t upd_idx_q;
    buffet_pkg::data_t upd_data_q;

    logic [buffet_pkg::SB_DEPTH-1:0] free;
    logic [buffet_pkg::SB_DEPTH-1:0] alloc_onehot;
    logic [buffet_pkg::SB_DEPTH-1:0] probe_hit;
    logic [buffet_pkg::SB_DEPTH-1:0] upd_hit;

    // Lowest free slot as a one-hot mask
    assign free = ~sb_valid_q;
    assign alloc_onehot = free & (~free + 1'b1);

    always_comb begin
        for (int i = 0; i < buffet_pkg::SB_DEPTH; i++) begin
            probe_hit[i] = sb_valid_q[i] && (sb_idx_q[i] == probe_idx_i);
            upd_hit[i] = sb_valid_q[i] && (sb_idx_q[i] == upd_idx_q);
        end
    end

    assign match_o = |probe_hit;
    assign full_o = &sb_valid_q;

    // Offset is taken relative to the head at arrival
    always_ff @(posedge clk or negedge nreset_i) begin
        if (!nreset_i) begin
            upd_valid_q <= 1'b0;
        end else begin
            upd_valid_q <= update_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid_i) begin
            upd_idx_q <= head_i + update_offset_i;
            upd_data_q <= update_data_i;
        end
    end

    // Clear on write-back, set on allocation
    // A clear only hits valid slots and allocation only takes free ones
    always_ff @(posedge clk or negedge nreset_i) begin
        if (!nreset_i) begin
            sb_valid_q <= '0;
        end else begin
            for (int i = 0; i < buffet_pkg::SB_DEPTH; i++) begin
                if (upd_valid_q && upd_hit[i]) begin
                    sb_valid_q[i] <= 1'b0;
                end else if (alloc_i && alloc_onehot[i]) begin
                    sb_valid_q[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < buffet_pkg::SB_DEPTH; i++) begin
            if (alloc_i && alloc_onehot[i]) begin
                sb_idx_q[i] <= alloc_idx_i;
            end
        end
    end

    // RAM write lands on the same edge as the clear
    always_comb begin
        update_wr_o.en = upd_valid_q;
        update_wr_o.idx = upd_idx_q;
        update_wr_o.data = upd_data_q;
    end

endmodule

/* verilog/buffet_window.sv */
/*
 * Buffet window
 * Keeps the head and tail pointers of the circular buffer, derives the
 * occupancy, answers credit requests one cycle later and forms the
 * push write port at the tail
 */
`timescale 1ns/1ps

module buffet_window (
    input  logic                clk,
    input  logic                nreset_i,
    input  logic                push_valid_i,
    input  buffet_pkg::data_t   push_data_i,
    input  logic                credit_req_i,
    input  logic                shrink_i,
    input  buffet_pkg::idx_t    shrink_amount_i,
    output buffet_pkg::idx_t    head_o,
    output buffet_pkg::count_t  occupancy_o,
    output logic                credit_valid_o,
    output buffet_pkg::count_t  credit_o,
    output buffet_pkg::wr_port_t push_wr_o
);

    // ------------------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------------------

    // Top bit of each pointer is the wrap bit
    // Low bits are the RAM index
    buffet_pkg::count_t head_q;
    buffet_pkg::count_t tail_q;
    buffet_pkg::count_t occupancy;

    // Difference modulo 2*DEPTH gives 0..DEPTH
    assign occupancy = tail_q - head_q;

    always_ff @(posedge clk or negedge nreset_i) begin
        if (!nreset_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            // Producer holds credit, so no overflow check
            if (push_valid_i) begin
                tail_q <= tail_q + 1'b1;
            end
            // Shrink frees entries from the head
            if (shrink_i) begin
                head_q <= head_q + buffet_pkg::count_t'(shrink_amount_i);
            end
        end
    end

    assign head_o = head_q[buffet_pkg::ADDR_W-1:0];
    assign occupancy_o = occupancy;

    // ------------------------------------------------------------------------
    // Credit reply
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge nreset_i) begin
        if (!nreset_i) begin
            credit_valid_o <= 1'b0;
        end else begin
            credit_valid_o <= credit_req_i;
        end
    end

    // Free space sampled at the request edge
    always_ff @(posedge clk) begin
        if (credit_req_i) begin
            credit_o <= buffet_pkg::count_t'(buffet_pkg::DEPTH) - occupancy;
        end
    end

    // Push goes straight into the RAM at the tail
    always_comb begin
        push_wr_o.en = push_valid_i;
        push_wr_o.idx = tail_q[buffet_pkg::ADDR_W-1:0];
        push_wr_o.data = push_data_i;
    end

endmodule

/* verilog/buffet_pkg.sv */
/*
 * Buffet shared definitions
 * Sizes of the circular buffer and scoreboard, the vector types that
 * carry data, indices and counts, the read request and RAM write port
 * structs, and the read FSM state encoding
 */
package buffet_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------

    // Width of one buffer entry
    localparam int DATA_W = 32;
    // Index width, 16 entries
    localparam int ADDR_W = 4;
    localparam int DEPTH = 16;
    // Outstanding will-update reads that can be tracked
    localparam int SB_DEPTH = 4;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------

    typedef logic [DATA_W-1:0] data_t;
    // Absolute index or offset from the head
    typedef logic [ADDR_W-1:0] idx_t;
    // One extra bit so that a full buffer (16) is representable
    typedef logic [ADDR_W:0] count_t;

    // Read request from the consumer, shrink reuses offset as amount
    typedef struct packed {
        idx_t offset;
        logic will_update;
        logic is_shrink;
    } read_req_t;

    // One RAM write port
    typedef struct packed {
        logic en;
        idx_t idx;
        data_t data;
    } wr_port_t;

    // Read FSM, one read held at a time
    typedef enum logic {
        RD_IDLE,
        RD_WAIT
    } rd_state_e;

endpackage
